/* common/lsu_consts.svh */
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// log2 of the store buffer entry count
`define SB_DEPTH 3

// store buffer entry count
`define SB_ENTRIES (1 << `SB_DEPTH)

`endif

/* common/rv32i_types_pkg.sv */
`default_nettype none

package rv32i_types_pkg;

    // store width, ISA funct3 encoding
    typedef enum logic [2:0] {
        sb = 3'b000,
        sh = 3'b001,
        sw = 3'b010
    } store_funct3_e;

    // load width, ISA funct3 encoding
    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_funct3_e;

    // one bit per byte lane
    typedef logic [3:0]  byte_mask_t;
    typedef logic [31:0] word_t;

endpackage

`default_nettype wire

/* common/lsu_mem_pkg.sv */
`default_nettype none

package lsu_mem_pkg;

    // write sequencer towards data memory
    // ws_idle waits for a buffered store,
    // ws_wait holds the request until the response
    typedef enum logic {
        ws_idle = 1'b0,
        ws_wait = 1'b1
    } write_state_e;

endpackage

`default_nettype wire

/* verilog/store_agu.sv */
`timescale 1ns/1ns
`default_nettype none

module store_agu (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        flush,
    input  logic                        st_valid,
    input  rv32i_types_pkg::store_funct3_e st_funct3,
    input  rv32i_types_pkg::word_t      st_base,
    input  rv32i_types_pkg::word_t      st_offset,
    input  rv32i_types_pkg::word_t      st_data,
    output logic                        agu_valid,
    output rv32i_types_pkg::word_t      agu_addr,
    output rv32i_types_pkg::word_t      agu_wdata,
    output rv32i_types_pkg::byte_mask_t agu_wmask
);
    import rv32i_types_pkg::*;

    word_t      sum;
    word_t      rep_data;
    word_t      lane_data;
    byte_mask_t mask_d;

    assign sum = st_base + st_offset;

    // width decode, data copied into every lane it may land in
    always_comb begin
        case (st_funct3)
            sb: begin
                mask_d   = 4'b0001 << sum[1:0];
                rep_data = {4{st_data[7:0]}};
            end
            sh: begin
                mask_d   = 4'b0011 << {sum[1], 1'b0};
                rep_data = {2{st_data[15:0]}};
            end
            sw: begin
                mask_d   = 4'b1111;
                rep_data = st_data;
            end
            default: begin
                mask_d   = 4'b0000;
                rep_data = '0;
            end
        endcase
    end

    // keep only the written lanes
    assign lane_data = rep_data & {{8{mask_d[3]}}, {8{mask_d[2]}},
                                   {8{mask_d[1]}}, {8{mask_d[0]}}};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            agu_valid <= 1'b0;
        end else begin
            agu_valid <= st_valid && !flush;
        end
    end

    always_ff @(posedge clk) begin
        if (st_valid) begin
            agu_addr  <= {sum[31:2], 2'b00};
            agu_wmask <= mask_d;
            agu_wdata <= lane_data;
        end
    end

endmodule

`default_nettype wire

/* store_buffer/store_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

`include "lsu_consts.svh"

module store_buffer (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        flush,
    input  logic                        agu_valid,
    input  rv32i_types_pkg::word_t      agu_addr,
    input  rv32i_types_pkg::byte_mask_t agu_wmask,
    input  rv32i_types_pkg::word_t      agu_wdata,
    input  logic                        sb_pop,
    output logic                        st_ready,
    output logic                        head_valid,
    output rv32i_types_pkg::word_t      head_addr,
    output rv32i_types_pkg::word_t      head_wdata,
    output rv32i_types_pkg::byte_mask_t head_wmask,
    output logic                        snap_valid [`SB_ENTRIES],
    output rv32i_types_pkg::word_t      snap_addr  [`SB_ENTRIES],
    output rv32i_types_pkg::word_t      snap_wdata [`SB_ENTRIES],
    output rv32i_types_pkg::byte_mask_t snap_wmask [`SB_ENTRIES]
);
    import rv32i_types_pkg::*;

    logic       valid_q [`SB_ENTRIES];
    word_t      addr_q  [`SB_ENTRIES];
    word_t      wdata_q [`SB_ENTRIES];
    byte_mask_t wmask_q [`SB_ENTRIES];

    // head is the next free slot, tail the oldest store
    logic [`SB_DEPTH-1:0] head_q;
    logic [`SB_DEPTH-1:0] tail_q;
    logic [`SB_DEPTH:0]   count_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            for (int i = 0; i < `SB_ENTRIES; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (flush) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            for (int i = 0; i < `SB_ENTRIES; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else begin
            if (agu_valid) begin
                valid_q[head_q] <= 1'b1;
                head_q          <= head_q + 1'b1;
            end
            if (sb_pop) begin
                valid_q[tail_q] <= 1'b0;
                tail_q          <= tail_q + 1'b1;
            end
            count_q <= count_q + (`SB_DEPTH+1)'(agu_valid) - (`SB_DEPTH+1)'(sb_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (agu_valid && !flush) begin
            addr_q[head_q]  <= agu_addr;
            wmask_q[head_q] <= agu_wmask;
            wdata_q[head_q] <= agu_wdata;
        end
    end

    // two free slots, one more store may sit in the agu register
    assign st_ready = (int'(count_q) <= `SB_ENTRIES - 2);

    // oldest entry towards the write sequencer
    assign head_valid = valid_q[tail_q];
    assign head_addr  = addr_q[tail_q];
    assign head_wmask = wmask_q[tail_q];
    assign head_wdata = wdata_q[tail_q];

    // index 0 is the newest store
    always_comb begin
        logic [`SB_DEPTH-1:0] slot;
        for (int i = 0; i < `SB_ENTRIES; i++) begin
            slot          = head_q - `SB_DEPTH'(i + 1);
            snap_valid[i] = valid_q[slot];
            snap_addr[i]  = addr_q[slot];
            snap_wmask[i] = wmask_q[slot];
            snap_wdata[i] = wdata_q[slot];
        end
    end

endmodule

`default_nettype wire

/* store_buffer/store_forward.sv */
`timescale 1ns/1ns
`default_nettype none

`include "lsu_consts.svh"

module store_forward (
    input  logic                          ld_valid,
    input  rv32i_types_pkg::word_t        ld_addr,
    input  rv32i_types_pkg::load_funct3_e ld_funct3,
    input  logic                          snap_valid [`SB_ENTRIES],
    input  rv32i_types_pkg::word_t        snap_addr  [`SB_ENTRIES],
    input  rv32i_types_pkg::word_t        snap_wdata [`SB_ENTRIES],
    input  rv32i_types_pkg::byte_mask_t   snap_wmask [`SB_ENTRIES],
    output rv32i_types_pkg::word_t        fwd_data,
    output rv32i_types_pkg::byte_mask_t   fwd_hit_mask,
    output logic                          fwd_full
);
    import rv32i_types_pkg::*;

    byte_mask_t need_mask;

    // bytes the load reads
    always_comb begin
        case (ld_funct3)
            lb, lbu: need_mask = 4'b0001 << ld_addr[1:0];
            lh, lhu: need_mask = 4'b0011 << {ld_addr[1], 1'b0};
            lw:      need_mask = 4'b1111;
            default: need_mask = 4'b0000;
        endcase
    end

    // walk oldest to newest so the newest match wins per lane
    always_comb begin
        fwd_hit_mask = '0;
        fwd_data     = '0;
        for (int i = `SB_ENTRIES - 1; i >= 0; i--) begin
            if (ld_valid && snap_valid[i] && (snap_addr[i][31:2] == ld_addr[31:2])) begin
                for (int b = 0; b < 4; b++) begin
                    if (snap_wmask[i][b]) begin
                        fwd_hit_mask[b]    = 1'b1;
                        fwd_data[8*b +: 8] = snap_wdata[i][8*b +: 8];
                    end
                end
            end
        end
    end

    // all needed bytes come from the buffer
    assign fwd_full = ld_valid && ((need_mask & ~fwd_hit_mask) == 4'b0000);

endmodule

`default_nettype wire

/* verilog/dmem_write_fsm.sv */
`timescale 1ns/1ns
`default_nettype none

module dmem_write_fsm (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        flush,
    input  logic                        head_valid,
    input  rv32i_types_pkg::word_t      head_addr,
    input  rv32i_types_pkg::byte_mask_t head_wmask,
    input  rv32i_types_pkg::word_t      head_wdata,
    input  logic                        dmem_resp,
    output logic                        sb_pop,
    output logic                        dmem_write,
    output rv32i_types_pkg::word_t      dmem_addr,
    output rv32i_types_pkg::word_t      dmem_wdata,
    output rv32i_types_pkg::byte_mask_t dmem_wmask
);
    import lsu_mem_pkg::*;

    write_state_e state_q;
    // buffer was flushed under an outstanding write
    logic         discard_q;
    logic         start;

    // sb_pop high means the head is the entry just written
    assign start = (state_q == ws_idle) && head_valid && !sb_pop && !flush;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q   <= ws_idle;
            discard_q <= 1'b0;
            sb_pop    <= 1'b0;
        end else begin
            sb_pop <= 1'b0;
            case (state_q)
                ws_idle: begin
                    if (start) begin
                        state_q <= ws_wait;
                    end
                end
                ws_wait: begin
                    if (dmem_resp) begin
                        state_q   <= ws_idle;
                        discard_q <= 1'b0;
                        sb_pop    <= !discard_q && !flush;
                    end else if (flush) begin
                        discard_q <= 1'b1;
                    end
                end
                default: state_q <= ws_idle;
            endcase
        end
    end

    // request payload, held for the whole write
    always_ff @(posedge clk) begin
        if (start) begin
            dmem_addr  <= head_addr;
            dmem_wmask <= head_wmask;
            dmem_wdata <= head_wdata;
        end
    end

    assign dmem_write = (state_q == ws_wait);

endmodule

`default_nettype wire

/* verilog/store_path.sv */
`timescale 1ns/1ns
`default_nettype none

`include "lsu_consts.svh"

module store_path (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          flush,
    input  logic                          st_valid,
    input  rv32i_types_pkg::store_funct3_e st_funct3,
    input  rv32i_types_pkg::word_t        st_base,
    input  rv32i_types_pkg::word_t        st_offset,
    input  rv32i_types_pkg::word_t        st_data,
    output logic                          st_ready,
    input  logic                          ld_valid,
    input  rv32i_types_pkg::word_t        ld_addr,
    input  rv32i_types_pkg::load_funct3_e ld_funct3,
    output rv32i_types_pkg::word_t        fwd_data,
    output rv32i_types_pkg::byte_mask_t   fwd_hit_mask,
    output logic                          fwd_full,
    output logic                          dmem_write,
    output rv32i_types_pkg::word_t        dmem_addr,
    output rv32i_types_pkg::byte_mask_t   dmem_wmask,
    output rv32i_types_pkg::word_t        dmem_wdata,
    input  logic                          dmem_resp
);
    import rv32i_types_pkg::*;

    // agu register to buffer
    logic       agu_valid;
    word_t      agu_addr;
    word_t      agu_wdata;
    byte_mask_t agu_wmask;

    // oldest entry and retire strobe
    logic       head_valid;
    word_t      head_addr;
    word_t      head_wdata;
    byte_mask_t head_wmask;
    logic       sb_pop;

    // newest-first view for forwarding
    logic       snap_valid [`SB_ENTRIES];
    word_t      snap_addr  [`SB_ENTRIES];
    word_t      snap_wdata [`SB_ENTRIES];
    byte_mask_t snap_wmask [`SB_ENTRIES];

    store_agu u_store_agu (
        .clk       (clk),
        .arst_n    (arst_n),
        .flush     (flush),
        .st_valid  (st_valid),
        .st_funct3 (st_funct3),
        .st_base   (st_base),
        .st_offset (st_offset),
        .st_data   (st_data),
        .agu_valid (agu_valid),
        .agu_addr  (agu_addr),
        .agu_wdata (agu_wdata),
        .agu_wmask (agu_wmask)
    );

    store_buffer u_store_buffer (
        .clk        (clk),
        .arst_n     (arst_n),
        .flush      (flush),
        .agu_valid  (agu_valid),
        .agu_addr   (agu_addr),
        .agu_wmask  (agu_wmask),
        .agu_wdata  (agu_wdata),
        .sb_pop     (sb_pop),
        .st_ready   (st_ready),
        .head_valid (head_valid),
        .head_addr  (head_addr),
        .head_wdata (head_wdata),
        .head_wmask (head_wmask),
        .snap_valid (snap_valid),
        .snap_addr  (snap_addr),
        .snap_wdata (snap_wdata),
        .snap_wmask (snap_wmask)
    );

    store_forward u_store_forward (
        .ld_valid     (ld_valid),
        .ld_addr      (ld_addr),
        .ld_funct3    (ld_funct3),
        .snap_valid   (snap_valid),
        .snap_addr    (snap_addr),
        .snap_wdata   (snap_wdata),
        .snap_wmask   (snap_wmask),
        .fwd_data     (fwd_data),
        .fwd_hit_mask (fwd_hit_mask),
        .fwd_full     (fwd_full)
    );

    dmem_write_fsm u_dmem_write_fsm (
        .clk        (clk),
        .arst_n     (arst_n),
        .flush      (flush),
        .head_valid (head_valid),
        .head_addr  (head_addr),
        .head_wmask (head_wmask),
        .head_wdata (head_wdata),
        .dmem_resp  (dmem_resp),
        .sb_pop     (sb_pop),
        .dmem_write (dmem_write),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_wmask (dmem_wmask)
    );

endmodule

`default_nettype wire

/* verif/store_path_sva.sv */
`timescale 1ns/1ns
`default_nettype none

module store_path_sva (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        st_valid,
    input  logic                        st_ready,
    input  logic                        sb_pop,
    input  logic                        dmem_write,
    input  logic                        dmem_resp,
    input  rv32i_types_pkg::word_t      dmem_addr,
    input  rv32i_types_pkg::byte_mask_t dmem_wmask,
    input  rv32i_types_pkg::word_t      dmem_wdata
);
    // failures seen so far, read by the testbench
    int assert_errors = 0;

    // a store is only legal while the buffer has room
    issue_when_ready: assert property (
        @(posedge clk) disable iff (!arst_n) st_valid |-> st_ready
    ) else begin
        assert_errors++;
        $error("store issued while st_ready is low");
    end

    // request payload held until the response
    dmem_stable: assert property (
        @(posedge clk) disable iff (!arst_n)
        (dmem_write && !dmem_resp) |=> $stable({dmem_addr, dmem_wmask, dmem_wdata})
    ) else begin
        assert_errors++;
        $error("dmem request changed while waiting for the response");
    end

    pop_single: assert property (
        @(posedge clk) disable iff (!arst_n) sb_pop |=> !sb_pop
    ) else begin
        assert_errors++;
        $error("sb_pop longer than one cycle");
    end

    no_write_after_reset: assert property (
        @(posedge clk) $rose(arst_n) |-> !dmem_write
    ) else begin
        assert_errors++;
        $error("dmem_write high right after reset");
    end

endmodule

`default_nettype wire

/* verif/store_path_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module store_path_tb;
    import rv32i_types_pkg::*;

    logic          clk;
    logic          arst_n;
    logic          flush;
    logic          st_valid;
    store_funct3_e st_funct3;
    word_t         st_base;
    word_t         st_offset;
    word_t         st_data;
    logic          st_ready;
    logic          ld_valid;
    word_t         ld_addr;
    load_funct3_e  ld_funct3;
    word_t         fwd_data;
    byte_mask_t    fwd_hit_mask;
    logic          fwd_full;
    logic          dmem_write;
    word_t         dmem_addr;
    byte_mask_t    dmem_wmask;
    word_t         dmem_wdata;
    logic          dmem_resp;

    word_t      mem [0:1023];
    // written lanes as memory holds them after the write
    word_t      stored;
    // writes in the order memory accepted them
    word_t      obs_addr [$];
    word_t      obs_data [$];
    byte_mask_t obs_mask [$];
    string      lines [$];
    int         errors  = 0;
    int         cycles  = 0;
    int         limit   = 100000;
    int         lat_min = 1;
    int         lat_max = 4;
    int         left    = -1;
    // cycles a store waited for st_ready
    int         stalls  = 0;

    store_path u_store_path (.*);

    bind store_path store_path_sva u_store_path_sva (
        .clk        (clk),
        .arst_n     (arst_n),
        .st_valid   (st_valid),
        .st_ready   (st_ready),
        .sb_pop     (sb_pop),
        .dmem_write (dmem_write),
        .dmem_resp  (dmem_resp),
        .dmem_addr  (dmem_addr),
        .dmem_wmask (dmem_wmask),
        .dmem_wdata (dmem_wdata)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout: the run hung after %0d cycles", cycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    // memory answers after a random latency
    always @(posedge clk) begin
        if (!arst_n) begin
            dmem_resp <= 1'b0;
            left = -1;
        end else if (dmem_resp) begin
            dmem_resp <= 1'b0;
        end else if (dmem_write) begin
            if (left < 0) begin
                left = lat_min - 1 + int'($urandom % 32'(lat_max - lat_min + 1));
            end
            if (left == 0) begin
                dmem_resp <= 1'b1;
                stored = '0;
                for (int b = 0; b < 4; b++) begin
                    if (dmem_wmask[b]) begin
                        mem[dmem_addr[11:2]][8*b +: 8] = dmem_wdata[8*b +: 8];
                        stored[8*b +: 8] = mem[dmem_addr[11:2]][8*b +: 8];
                    end
                end
                obs_addr.push_back(dmem_addr);
                obs_mask.push_back(dmem_wmask);
                obs_data.push_back(stored);
                left = -1;
            end else begin
                left--;
            end
        end
    end

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            errors++;
            $display("error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_mask(input string name, input byte_mask_t exp, input byte_mask_t act);
        if (exp !== act) begin
            errors++;
            $display("error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            errors++;
            $display("error %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // keeps command lines, drops comments and blank lines
    task automatic read_tests();
        int    fd;
        string line;
        fd = $fopen("verif/store_path_tests.txt", "r");
        if (fd == 0) begin
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.substr(0, 0) != "#") begin
                lines.push_back(line);
            end
        end
        $fclose(fd);
    endtask

    initial begin
        string      cmd;
        string      name;
        word_t      a;
        word_t      b;
        word_t      d;
        logic [2:0] f3;
        byte_mask_t m;
        logic       full;
        int         n;
        int         quiet;
        void'($urandom(64));
        arst_n    = 1'b0;
        flush     = 1'b0;
        st_valid  = 1'b0;
        st_funct3 = sw;
        st_base   = '0;
        st_offset = '0;
        st_data   = '0;
        ld_valid  = 1'b0;
        ld_addr   = '0;
        ld_funct3 = lw;
        dmem_resp = 1'b0;
        for (int i = 0; i < 1024; i++) begin
            mem[i] = 32'(i * 4) ^ 32'h5a5a5a5a;
        end
        read_tests();
        if (lines.size() == 0) begin
            errors++;
            $display("no test commands could be read from the test file");
        end
        limit = 40 * lines.size() + 20;
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_flag("reset_dmem_write", 1'b0, dmem_write);
        check_flag("reset_fwd_full", 1'b0, fwd_full);
        check_flag("reset_st_ready", 1'b1, st_ready);
        foreach (lines[i]) begin
            void'($sscanf(lines[i], "%s", cmd));
            @(posedge clk);
            st_valid <= 1'b0;
            flush    <= 1'b0;
            ld_valid <= 1'b0;
            case (cmd)
                "S": begin
                    void'($sscanf(lines[i], "%s %h %h %h %h", cmd, f3, a, b, d));
                    // one idle cycle so the agu store has landed before st_ready is read
                    @(posedge clk);
                    @(negedge clk);
                    while (!st_ready) begin
                        stalls++;
                        @(negedge clk);
                    end
                    @(posedge clk);
                    st_valid  <= 1'b1;
                    st_funct3 <= store_funct3_e'(f3);
                    st_base   <= a;
                    st_offset <= b;
                    st_data   <= d;
                end
                "L": begin
                    void'($sscanf(lines[i], "%s %s %h %h %h %h %h", cmd, name, a, f3, d, m, full));
                    ld_valid  <= 1'b1;
                    ld_addr   <= a;
                    ld_funct3 <= load_funct3_e'(f3);
                    @(negedge clk);
                    check_word({name, "_data"}, d, fwd_data);
                    check_mask({name, "_hit"}, m, fwd_hit_mask);
                    check_flag({name, "_full"}, full, fwd_full);
                end
                "M": begin
                    void'($sscanf(lines[i], "%s %s %h %h %h", cmd, name, a, m, d));
                    while (obs_addr.size() == 0) @(posedge clk);
                    check_word({name, "_addr"}, a, obs_addr.pop_front());
                    check_mask({name, "_mask"}, m, obs_mask.pop_front());
                    check_word({name, "_data"}, d, obs_data.pop_front());
                end
                "D": begin
                    quiet = 0;
                    while (quiet < 8) begin
                        @(posedge clk);
                        quiet = dmem_write ? 0 : quiet + 1;
                    end
                end
                "F": flush <= 1'b1;
                "W": begin
                    void'($sscanf(lines[i], "%s %d", cmd, n));
                    repeat (n) @(posedge clk);
                end
                "R": void'($sscanf(lines[i], "%s %d %d", cmd, lat_min, lat_max));
                default: begin
                    errors++;
                    $display("unknown command in the test file: %s", lines[i]);
                end
            endcase
        end
        @(posedge clk);
        st_valid <= 1'b0;
        ld_valid <= 1'b0;
        if (obs_addr.size() != 0) begin
            errors++;
            $display("memory saw %0d writes that no test expected", obs_addr.size());
        end
        // the slow burst has to fill the buffer at least once
        check_flag("backpressure_st_ready_low", 1'b1, stalls != 0);
        errors += u_store_path.u_store_path_sva.assert_errors;
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/store_path_tests.txt */
# S funct3 base offset data | L name addr funct3 data hit_mask full | M name addr mask data
# D drain | F flush | W cycles | R min_latency max_latency (all numbers hex except W and R)
S 0 00000100 00000000 123456aa
S 0 00000100 00000001 000000bb
S 0 000000ff 00000003 000000cc
S 0 00000104 ffffffff 000000dd
S 1 00000108 00000000 00001234
S 1 00000108 00000002 00005678
S 2 0000010c 00000000 cafef00d
D
M sb_off0 00000100 1 000000aa
M sb_off1 00000100 2 0000bb00
M sb_off2 00000100 4 00cc0000
M sb_off3 00000100 8 dd000000
M sh_off0 00000108 3 00001234
M sh_off2 00000108 c 56780000
M sw_off0 0000010c f cafef00d
R 12 12
S 2 00000200 00000000 aabbccdd
S 1 00000200 00000002 00005566
S 0 00000200 00000000 ffffff77
S 0 00000204 00000001 00000099
W 1
L merge 00000200 2 5566cc77 f 1
L partial 00000204 1 00009900 2 0
S 2 00000300 00000000 10000001
S 2 00000300 00000004 10000002
S 2 00000300 00000008 10000003
S 2 00000300 0000000c 10000004
S 2 00000300 00000010 10000005
S 2 00000300 00000014 10000006
D
M fwd_sw 00000200 f aabbccdd
M fwd_sh 00000200 c 55660000
M fwd_sb 00000200 1 00000077
M fwd_part 00000204 2 00009900
M burst0 00000300 f 10000001
M burst1 00000304 f 10000002
M burst2 00000308 f 10000003
M burst3 0000030c f 10000004
M burst4 00000310 f 10000005
M burst5 00000314 f 10000006
R 6 6
S 2 00000400 00000000 01020304
S 2 00000404 00000000 05060708
F
L flushed 00000404 2 00000000 0 0
D
M flush_sent 00000400 f 01020304

/* store_path.f */
+incdir+common
common/rv32i_types_pkg.sv
common/lsu_mem_pkg.sv
verilog/store_agu.sv
store_buffer/store_buffer.sv
store_buffer/store_forward.sv
verilog/dmem_write_fsm.sv
verilog/store_path.sv
verif/store_path_sva.sv
verif/store_path_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the store path testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f store_path.f \
    --top-module store_path_tb -o store_path_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/store_path_sim +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Result: FAILED" sim.log; then
    exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0
